// File: logic/br_macros.svh
`ifndef BR_MACROS_SVH
`define BR_MACROS_SVH

// data and address width
`define BR_XLEN 32

// reorder buffer tag
`define BR_ROB_ID_W 5

// physical register index
`define BR_PHY_W 6

// entries in the branch issue queue
`define BR_QUEUE_DEPTH 4

`endif

// File: logic/br_pkg.sv
`include "br_macros.svh"

package br_pkg;

    // branch micro-op opcodes
    typedef enum logic [3:0] {
        BR_BEQ     = 4'd0,
        BR_BNE     = 4'd1,
        BR_BLT     = 4'd2,
        BR_BGE     = 4'd3,
        BR_BLTU    = 4'd4,
        BR_BGEU    = 4'd5,
        BR_JAL     = 4'd6,
        BR_JALR    = 4'd7,
        BR_ILLEGAL = 4'd15
    } br_op_t;

    //////////////////////////////
    // micro-op carried from dispatch to the branch unit
    //////////////////////////////

    typedef struct packed {
        br_op_t                     op;
        logic [`BR_XLEN-1:0]        pc;
        logic [`BR_XLEN-1:0]        rs1_value;
        logic [`BR_XLEN-1:0]        rs2_value;
        logic [`BR_XLEN-1:0]        imm;
        logic                       predict_taken;
        logic [`BR_XLEN-1:0]        predict_target;
        logic [`BR_ROB_ID_W-1:0]    rob_id;
        logic [`BR_PHY_W-1:0]       rd_phy;
        // architectural rd of a jump
        logic [4:0]                 rd_arch;
        logic                       rd_write;
    } br_uop_t;

endpackage

// File: logic/br_dispatch.sv
`timescale 1ns/1ns
`include "br_macros.svh"

module br_dispatch import br_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [31:0]                 instr,
    input  logic [`BR_XLEN-1:0]         pc,
    input  logic [`BR_XLEN-1:0]         rs1_value,
    input  logic [`BR_XLEN-1:0]         rs2_value,
    input  logic                        predict_taken,
    input  logic [`BR_XLEN-1:0]         predict_target,
    input  logic [`BR_ROB_ID_W-1:0]     rob_id,
    input  logic [`BR_PHY_W-1:0]        rd_phy,
    output logic                        uop_valid,
    input  logic                        uop_ready,
    output br_uop_t                     uop
);

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [`BR_XLEN-1:0]    imm_b;
    logic [`BR_XLEN-1:0]    imm_j;
    logic [`BR_XLEN-1:0]    imm_i;
    br_uop_t                dec;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // sign-extended immediates
    assign imm_b = {{(`BR_XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{(`BR_XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_i = {{(`BR_XLEN-12){instr[31]}}, instr[31:20]};

    //////////////////////////////
    // decode
    //////////////////////////////

    always_comb begin
        dec                = '0;
        dec.pc             = pc;
        dec.rs1_value      = rs1_value;
        dec.rs2_value      = rs2_value;
        dec.predict_taken  = predict_taken;
        dec.predict_target = predict_target;
        dec.rob_id         = rob_id;
        dec.rd_phy         = rd_phy;
        dec.op             = BR_ILLEGAL;
        unique case (opcode)
            OPC_BRANCH: begin
                dec.imm = imm_b;
                unique case (funct3)
                    3'b000:  dec.op = BR_BEQ;
                    3'b001:  dec.op = BR_BNE;
                    3'b100:  dec.op = BR_BLT;
                    3'b101:  dec.op = BR_BGE;
                    3'b110:  dec.op = BR_BLTU;
                    3'b111:  dec.op = BR_BGEU;
                    default: dec.op = BR_ILLEGAL;
                endcase
            end
            OPC_JAL: begin
                dec.op      = BR_JAL;
                dec.imm     = imm_j;
                dec.rd_arch = instr[11:7];
            end
            OPC_JALR: begin
                dec.op      = (funct3 == 3'b000) ? BR_JALR : BR_ILLEGAL;
                dec.imm     = imm_i;
                dec.rd_arch = instr[11:7];
            end
            default: dec.imm = '0;
        endcase
        dec.rd_write = (dec.op == BR_JAL || dec.op == BR_JALR) && (dec.rd_arch != 5'd0);
    end

    // output register empty or draining this cycle
    assign in_ready = !uop_valid || uop_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            uop_valid <= 1'b0;
        end else if (in_ready) begin
            uop_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            uop <= dec;
        end
    end

endmodule

// File: logic/br_issue_queue.sv
`timescale 1ns/1ns

module br_issue_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  payload_t    in_data,
    output logic        out_valid,
    input  logic        out_ready,
    output payload_t    out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    localparam logic [PTR_W-1:0] LAST_IDX  = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(DEPTH);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               do_write;
    logic               do_read;

    //////////////////////////////
    // handshakes
    //////////////////////////////

    assign full      = (count == FULL_CNT);
    assign out_valid = (count != '0);
    // a full queue still takes a word when the head leaves
    assign in_ready  = !full || out_ready;

    assign do_write  = in_valid && in_ready;
    assign do_read   = out_valid && out_ready;

    assign out_data  = mem[rd_ptr];

    //////////////////////////////
    // pointers and count
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            end
            unique case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

// File: logic/br_unit.sv
`timescale 1ns/1ns
`include "br_macros.svh"

module br_unit import br_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        uop_valid,
    output logic                        uop_ready,
    input  br_uop_t                     uop,
    output logic                        res_valid,
    input  logic                        res_ready,
    output logic [`BR_ROB_ID_W-1:0]     res_rob_id,
    output logic [`BR_PHY_W-1:0]        res_rd_phy,
    output logic [`BR_XLEN-1:0]         res_rd_value,
    output logic [`BR_XLEN-1:0]         res_target,
    output logic                        res_rd_write,
    output logic                        res_mispredict
);

    br_uop_t                ex_uop;
    logic                   ex_valid;
    logic                   res_take;

    logic signed [`BR_XLEN-1:0] a_s;
    logic signed [`BR_XLEN-1:0] b_s;
    logic [`BR_XLEN-1:0]    a_u;
    logic [`BR_XLEN-1:0]    b_u;
    logic                   taken;
    logic                   mispredict;
    logic [`BR_XLEN-1:0]    target;
    logic [`BR_XLEN-1:0]    link;
    logic [`BR_XLEN-1:0]    next_pc;

    //////////////////////////////
    // stage control
    //////////////////////////////

    // result stage empty or handing off
    assign res_take  = !res_valid || res_ready;
    assign uop_ready = !ex_valid || res_take;

    //////////////////////////////
    // execute stage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (uop_ready) begin
            ex_valid <= uop_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (uop_valid && uop_ready) begin
            ex_uop <= uop;
        end
    end

    assign a_u = ex_uop.rs1_value;
    assign b_u = ex_uop.rs2_value;
    assign a_s = signed'(ex_uop.rs1_value);
    assign b_s = signed'(ex_uop.rs2_value);

    // branch condition
    always_comb begin
        unique case (ex_uop.op)
            BR_BEQ:  taken = (a_u == b_u);
            BR_BNE:  taken = (a_u != b_u);
            BR_BLT:  taken = (a_s <  b_s);
            BR_BGE:  taken = (a_s >= b_s);
            BR_BLTU: taken = (a_u <  b_u);
            BR_BGEU: taken = (a_u >= b_u);
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jalr clears bit 0 of the sum
    always_comb begin
        if (ex_uop.op == BR_JALR) begin
            target = (ex_uop.rs1_value + ex_uop.imm) & ~`BR_XLEN'(1);
        end else begin
            target = ex_uop.pc + ex_uop.imm;
        end
    end

    assign link    = ex_uop.pc + `BR_XLEN'(4);
    assign next_pc = taken ? target : link;

    assign mispredict = (taken != ex_uop.predict_taken) ||
                        (taken && (target != ex_uop.predict_target));

    //////////////////////////////
    // result stage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (res_take) begin
            res_valid <= ex_valid;
        end
    end

    // payload held while stalled
    always_ff @(posedge clk) begin
        if (ex_valid && res_take) begin
            res_rob_id     <= ex_uop.rob_id;
            res_rd_phy     <= ex_uop.rd_phy;
            res_rd_value   <= link;
            res_target     <= next_pc;
            res_rd_write   <= ex_uop.rd_write;
            res_mispredict <= mispredict;
        end
    end

endmodule

// File: logic/br_subsystem.sv
`timescale 1ns/1ns
`include "br_macros.svh"

module br_subsystem import br_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [31:0]                 instr,
    input  logic [`BR_XLEN-1:0]         pc,
    input  logic [`BR_XLEN-1:0]         rs1_value,
    input  logic [`BR_XLEN-1:0]         rs2_value,
    input  logic                        predict_taken,
    input  logic [`BR_XLEN-1:0]         predict_target,
    input  logic [`BR_ROB_ID_W-1:0]     rob_id,
    input  logic [`BR_PHY_W-1:0]        rd_phy,
    output logic                        res_valid,
    input  logic                        res_ready,
    output logic [`BR_ROB_ID_W-1:0]     res_rob_id,
    output logic [`BR_PHY_W-1:0]        res_rd_phy,
    output logic [`BR_XLEN-1:0]         res_rd_value,
    output logic [`BR_XLEN-1:0]         res_target,
    output logic                        res_rd_write,
    output logic                        res_mispredict
);

    // dispatch to queue
    logic       uop_valid;
    logic       uop_ready;
    br_uop_t    uop;

    // queue to branch unit
    logic       iq_valid;
    logic       iq_ready;
    br_uop_t    iq_uop;

    br_dispatch dispatch0 (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .instr          (instr),
        .pc             (pc),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .predict_taken  (predict_taken),
        .predict_target (predict_target),
        .rob_id         (rob_id),
        .rd_phy         (rd_phy),
        .uop_valid      (uop_valid),
        .uop_ready      (uop_ready),
        .uop            (uop)
    );

    br_issue_queue #(
        .payload_t  (br_uop_t),
        .DEPTH      (`BR_QUEUE_DEPTH)
    ) queue0 (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (uop_valid),
        .in_ready   (uop_ready),
        .in_data    (uop),
        .out_valid  (iq_valid),
        .out_ready  (iq_ready),
        .out_data   (iq_uop)
    );

    br_unit unit0 (
        .clk            (clk),
        .rst            (rst),
        .uop_valid      (iq_valid),
        .uop_ready      (iq_ready),
        .uop            (iq_uop),
        .res_valid      (res_valid),
        .res_ready      (res_ready),
        .res_rob_id     (res_rob_id),
        .res_rd_phy     (res_rd_phy),
        .res_rd_value   (res_rd_value),
        .res_target     (res_target),
        .res_rd_write   (res_rd_write),
        .res_mispredict (res_mispredict)
    );

endmodule

// File: verif/br_checker.sv
`timescale 1ns/1ns
`include "br_macros.svh"

module br_checker (
    input logic                         clk,
    input logic                         rst,
    input logic                         in_valid,
    input logic                         in_ready,
    input logic [31:0]                  instr,
    input logic [`BR_XLEN-1:0]          pc,
    input logic [`BR_XLEN-1:0]          rs1_value,
    input logic [`BR_XLEN-1:0]          rs2_value,
    input logic                         predict_taken,
    input logic [`BR_XLEN-1:0]          predict_target,
    input logic [`BR_ROB_ID_W-1:0]      rob_id,
    input logic [`BR_PHY_W-1:0]         rd_phy,
    input logic                         res_valid,
    input logic                         res_ready,
    input logic [`BR_ROB_ID_W-1:0]      res_rob_id,
    input logic [`BR_PHY_W-1:0]         res_rd_phy,
    input logic [`BR_XLEN-1:0]          res_rd_value,
    input logic [`BR_XLEN-1:0]          res_target,
    input logic                         res_rd_write,
    input logic                         res_mispredict
);

    localparam int RES_W = `BR_ROB_ID_W + `BR_PHY_W + 2 * `BR_XLEN + 2;
    // dispatch register, queue entries and both unit stages
    localparam int CAPACITY = 3 + `BR_QUEUE_DEPTH;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    int unsigned            fail_count = 0;
    int unsigned            pushed;
    int unsigned            popped;
    int unsigned            inflight;
    logic [RES_W-1:0]       exp_mem [16];
    logic [RES_W-1:0]       exp_new;
    logic [RES_W-1:0]       exp_head;
    logic [RES_W-1:0]       res_word;
    logic [`BR_XLEN-1:0]    imm;
    logic [`BR_XLEN-1:0]    tgt;
    logic [`BR_XLEN-1:0]    link;
    logic                   tk;
    logic                   jump;
    logic                   mis;
    logic                   legal;

    //////////////////////////////
    // reference model
    //////////////////////////////

    always_comb begin
        jump = (instr[6:0] != OPC_BRANCH);
        if (instr[6:0] == OPC_JAL) begin
            imm = {{(`BR_XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        end else if (jump) begin
            imm = {{(`BR_XLEN-12){instr[31]}}, instr[31:20]};
        end else begin
            imm = {{(`BR_XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        end
        case (instr[14:12])
            3'b000:  tk = (rs1_value == rs2_value);
            3'b001:  tk = (rs1_value != rs2_value);
            3'b100:  tk = ($signed(rs1_value) < $signed(rs2_value));
            3'b101:  tk = ($signed(rs1_value) >= $signed(rs2_value));
            3'b110:  tk = (rs1_value < rs2_value);
            default: tk = (rs1_value >= rs2_value);
        endcase
        tk = tk || jump;
        if (instr[6:0] == OPC_JALR) begin
            tgt = (rs1_value + imm) & ~(`BR_XLEN'(1));
        end else begin
            tgt = pc + imm;
        end
        link = pc + `BR_XLEN'(4);
        mis = (tk != predict_taken) || (tk && (tgt != predict_target));
        exp_new = {rob_id, rd_phy, link, tk ? tgt : link, jump && (instr[11:7] != 5'd0), mis};
    end

    // only branch and jump words are offered
    assign legal = (instr[6:0] == OPC_BRANCH && instr[14:13] != 2'b01) ||
                   (instr[6:0] == OPC_JAL) ||
                   (instr[6:0] == OPC_JALR && instr[14:12] == 3'b000);

    always_ff @(posedge clk) begin
        if (rst) begin
            pushed <= 0;
            popped <= 0;
        end else begin
            if (in_valid && in_ready) begin
                exp_mem[pushed[3:0]] <= exp_new;
                pushed <= pushed + 1;
            end
            if (res_valid && res_ready) begin
                popped <= popped + 1;
            end
        end
    end

    assign inflight = pushed - popped;
    assign exp_head = exp_mem[popped[3:0]];
    assign res_word = {res_rob_id, res_rd_phy, res_rd_value, res_target,
                       res_rd_write, res_mispredict};

    //////////////////////////////
    // properties
    //////////////////////////////

    a_reset: assert property (@(posedge clk) rst |=> !res_valid && in_ready)
        else begin
            $error("[ERROR] %0t outputs not idle after reset", $time);
            fail_count++;
        end

    a_legal: assert property (@(posedge clk) disable iff (rst) in_valid |-> legal)
        else begin
            $error("[ERROR] %0t word %h is not a branch or jump", $time, $sampled(instr));
            fail_count++;
        end

    a_result: assert property (@(posedge clk) disable iff (rst)
        res_valid && res_ready |-> (inflight != 0) && (res_word == exp_head))
        else begin
            $error("[ERROR] %0t result for rob %0d differs from the reference",
                   $time, $sampled(res_rob_id));
            fail_count++;
        end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res_word))
        else begin
            $error("[ERROR] %0t stalled result changed", $time);
            fail_count++;
        end

    a_full: assert property (@(posedge clk) disable iff (rst)
        (inflight == CAPACITY) && !res_ready |-> !in_ready)
        else begin
            $error("[ERROR] %0t input accepted with every stage full", $time);
            fail_count++;
        end

endmodule

// File: verif/br_tb.sv
`timescale 1ns/1ns
`include "br_macros.svh"

module br_tb;

    localparam int N_COND = 24;
    localparam int N_JUMP = 8;
    localparam int N_MIX  = 40;
    localparam int N_FULL = 12;
    localparam int LIMIT  = (N_COND + N_JUMP + N_MIX + N_FULL) * 20;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       in_valid;
    logic                       in_ready;
    logic [31:0]                instr;
    logic [`BR_XLEN-1:0]        pc;
    logic [`BR_XLEN-1:0]        rs1_value;
    logic [`BR_XLEN-1:0]        rs2_value;
    logic                       predict_taken;
    logic [`BR_XLEN-1:0]        predict_target;
    logic [`BR_ROB_ID_W-1:0]    rob_id;
    logic [`BR_PHY_W-1:0]       rd_phy;
    logic                       res_valid;
    logic                       res_ready;
    logic [`BR_ROB_ID_W-1:0]    res_rob_id;
    logic [`BR_PHY_W-1:0]       res_rd_phy;
    logic [`BR_XLEN-1:0]        res_rd_value;
    logic [`BR_XLEN-1:0]        res_target;
    logic                       res_rd_write;
    logic                       res_mispredict;

    logic [15:0]    lfsr = 16'd42278;
    // 0 always ready, 1 random stalls, 2 held low
    int             ready_mode;
    int             sent;
    int             seen;
    int             blocked;
    int             tb_errors;
    int             errors_seen;
    int             tests_run;
    int             tests_bad;

    br_subsystem dut0 (.*);

    bind br_subsystem br_checker checker0 (.*);

    always #2 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    always @(negedge clk) begin
        logic [31:0] r;
        if (ready_mode == 1) begin
            rand_bits(2, r);
            res_ready = (r[1:0] != 2'b00);
        end else begin
            res_ready = (ready_mode == 0);
        end
    end

    always @(posedge clk) begin
        if (!rst && res_valid && res_ready) begin
            seen <= seen + 1;
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // kind 0..5 picks a condition, 6 is jal, 7 is jalr
    task automatic send_kind(input int kind, input int pat);
        logic [2:0]     f3;
        logic [31:0]    r;
        logic [31:0]    imm;
        logic [31:0]    tgt;
        logic [4:0]     rd;
        @(negedge clk);
        f3 = 3'((kind < 2) ? kind : kind + 2);
        rand_bits(30, r);
        pc = {r[29:0], 2'b00};
        rand_bits(32, rs1_value);
        rand_bits(32, rs2_value);
        case (pat)
            0: rs2_value = rs1_value;
            1: begin
                rs1_value[`BR_XLEN-1] = 1'b1;
                rs2_value[`BR_XLEN-1] = 1'b0;
            end
            2: begin
                rs1_value[`BR_XLEN-1] = 1'b0;
                rs2_value[`BR_XLEN-1:`BR_XLEN-16] = 16'hffff;
            end
            default: ;
        endcase
        rand_bits(6, r);
        rd_phy = r[5:0];
        rd = 5'd0;
        if (kind >= 6 && pat % 2 == 1) begin
            rand_bits(5, r);
            rd = r[4:0] | 5'd1;
        end
        rand_bits((kind == 6) ? 20 : 12, r);
        if (kind < 6) begin
            imm = {{19{r[11]}}, r[11:0], 1'b0};
            instr = {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
            tgt = pc + imm;
        end else if (kind == 6) begin
            imm = {{11{r[19]}}, r[19:0], 1'b0};
            instr = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            tgt = pc + imm;
        end else begin
            imm = {{20{r[11]}}, r[11:0]};
            instr = {imm[11:0], 5'd1, 3'b000, rd, 7'b1100111};
            tgt = (rs1_value + imm) & 32'hffff_fffe;
        end
        // jumps with pat 2 or 3 carry a correct prediction
        if (kind >= 6 && pat >= 2) begin
            predict_taken = 1'b1;
            predict_target = tgt;
        end else begin
            rand_bits(2, r);
            predict_taken = r[0];
            predict_target = r[1] ? tgt : tgt ^ 32'h10;
        end
        rob_id = `BR_ROB_ID_W'(sent);
        in_valid = 1'b1;
        #1;
        while (!in_ready) begin
            blocked++;
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        sent++;
    endtask

    task automatic finish_test(input string name);
        int errs;
        @(negedge clk);
        in_valid = 1'b0;
        while (seen != sent) begin
            @(negedge clk);
        end
        errs = tb_errors + int'(dut0.checker0.fail_count) - errors_seen;
        errors_seen += errs;
        tests_run++;
        if (errs != 0) begin
            tests_bad++;
        end
        $display("test %s done at %0t, %0d results, %0d errors", name, $time, seen, errs);
        @(posedge clk);
    endtask

    initial begin
        logic [31:0] r;
        rst = 1'b1;
        in_valid = 1'b0;
        instr = '0;
        pc = '0;
        rs1_value = '0;
        rs2_value = '0;
        predict_taken = 1'b0;
        predict_target = '0;
        rob_id = '0;
        rd_phy = '0;
        res_ready = 1'b1;
        ready_mode = 0;
        sent = 0;
        seen = 0;
        blocked = 0;
        tb_errors = 0;
        errors_seen = 0;
        tests_run = 0;
        tests_bad = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        finish_test("reset");

        for (int k = 0; k < N_COND; k++) begin
            send_kind(k % 6, k / 6);
        end
        finish_test("branch_cond");

        for (int k = 0; k < N_JUMP; k++) begin
            send_kind(6 + k % 2, k / 2);
        end
        finish_test("jumps");

        ready_mode = 1;
        for (int k = 0; k < N_MIX; k++) begin
            rand_bits(3, r);
            send_kind(int'(r[2:0]), k % 4);
        end
        finish_test("backpressure");

        // long stall fills every stage
        ready_mode = 2;
        blocked = 0;
        fork
            begin
                for (int k = 0; k < N_FULL; k++) begin
                    send_kind(k % 8, k % 4);
                end
            end
            begin
                repeat (30) @(posedge clk);
                ready_mode = 0;
            end
        join
        assert (blocked > 0) else begin
            $error("in_ready never fell while results were held back");
            tb_errors++;
        end
        finish_test("full_queue");

        $display("%0d tests run, %0d with errors, %0d errors in all",
                 tests_run, tests_bad, errors_seen);
        if (tests_bad == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #((LIMIT + 8) * 4);
        $display("watchdog expired after %0d cycles, the run did not finish", LIMIT);
        $display("tests failed");
        $finish;
    end

endmodule

// File: all.f
+incdir+logic
logic/br_pkg.sv
logic/br_dispatch.sv
logic/br_issue_queue.sv
logic/br_unit.sv
logic/br_subsystem.sv
verif/br_checker.sv
verif/br_tb.sv

// File: Makefile
# branch resolution subsystem, Verilator simulation

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run br_tb and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module br_tb \
		-Mdir obj_dir -f all.f
	./obj_dir/Vbr_tb +verilator+error+limit+1000 2>&1 | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
